/* logic/ccu_pkg.sv */
// Victim queue shared definitions
// Sizes, vector types, bus structs and the writeback state encoding

`default_nettype none

package ccu_pkg;

    // Sizes for the single supported configuration
    localparam int ADDR_WIDTH   = 32;
    localparam int DATA_WIDTH   = 32;
    localparam int DATA_SIZE    = 4;
    localparam int LINE_SIZE    = 32;
    localparam int LINE_WIDTH   = 256;
    localparam int OFFSET_WIDTH = 5;
    localparam int VQ_DEPTH     = 4;
    localparam int VQ_IDX_WIDTH = 2;

    typedef logic [ADDR_WIDTH-1:0]              addr_t;
    typedef logic [ADDR_WIDTH-OFFSET_WIDTH-1:0] line_addr_t;
    typedef logic [OFFSET_WIDTH-1:0]            offset_t;
    typedef logic [DATA_WIDTH-1:0]              word_t;
    typedef logic [DATA_SIZE-1:0]               byte_sel_t;
    typedef logic [LINE_WIDTH-1:0]              line_t;
    typedef logic [VQ_IDX_WIDTH-1:0]            vq_idx_t;
    typedef logic [VQ_DEPTH-1:0]                vq_sel_t;

    // Evicted line offered to the queue
    typedef struct packed {
        line_addr_t addr;
        line_t      data;
    } victim_t;

    // Load probing the queue
    typedef struct packed {
        addr_t     addr;
        byte_sel_t byte_sel;
    } lookup_req_t;

    typedef struct packed {
        logic  hit;
        word_t data;
    } lookup_rsp_t;

    // Full-line write to memory, byte address is addr with a zero offset
    typedef struct packed {
        line_addr_t addr;
        line_t      data;
    } ccu_req_t;

    typedef enum logic [0:0] {
        WB_IDLE,
        WB_REQ
    } wb_state_t;

endpackage

`default_nettype wire

/* logic/vq_queue_ctrl.sv */
// Victim queue pointer control
// Ring head/tail pointers, one-hot allocate and clear selects, full flag

`timescale 1ns/1ps
`default_nettype none

module vq_queue_ctrl
    import ccu_pkg::*;
(
    input  logic    clk,
    input  logic    i_rst_n,
    input  logic    i_victim_valid,
    input  logic    i_pop,
    output vq_sel_t o_alloc_sel,
    output vq_sel_t o_clear_sel,
    output vq_idx_t o_head,
    output logic    o_full
);

    vq_idx_t                 head_q;
    vq_idx_t                 tail_q;
    logic [VQ_IDX_WIDTH:0]   count_q;
    logic                    alloc;

    // Count needs one extra bit to tell full from empty
    assign o_full = (count_q == (VQ_IDX_WIDTH+1)'(VQ_DEPTH));
    assign alloc  = i_victim_valid & ~o_full;

    assign o_alloc_sel = alloc ? (vq_sel_t'(1) << tail_q) : '0;
    assign o_clear_sel = i_pop ? (vq_sel_t'(1) << head_q) : '0;
    assign o_head      = head_q;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (alloc) begin
                tail_q <= tail_q + 1'b1;
            end
            if (i_pop) begin
                head_q <= head_q + 1'b1;
            end
            // Simultaneous allocate and pop leave the count unchanged
            case ({alloc, i_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/vq_entry.sv */
// Victim queue entry
// Holds one evicted line and compares its line address against a load

`timescale 1ns/1ps
`default_nettype none

module vq_entry
    import ccu_pkg::*;
(
    input  logic       clk,
    input  logic       i_rst_n,
    input  logic       i_alloc_en,
    input  victim_t    i_alloc,
    input  logic       i_clear,
    input  line_addr_t i_lookup_addr,
    output logic       o_valid,
    output line_addr_t o_line_addr,
    output line_t      o_data,
    output logic       o_hit
);

    logic       valid_q;
    line_addr_t addr_q;
    line_t      data_q;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            valid_q <= 1'b0;
        end else if (i_alloc_en) begin
            valid_q <= 1'b1;
        end else if (i_clear) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (i_alloc_en) begin
            addr_q <= i_alloc.addr;
            data_q <= i_alloc.data;
        end
    end

    // Address match for the load probe
    assign o_hit = valid_q & (addr_q == i_lookup_addr);

    assign o_valid     = valid_q;
    assign o_line_addr = addr_q;
    assign o_data      = data_q;

endmodule

`default_nettype wire

/* logic/vq_lookup.sv */
// Victim queue lookup stage
// Picks the hitting entry, extracts the load bytes and registers the answer

`timescale 1ns/1ps
`default_nettype none

module vq_lookup
    import ccu_pkg::*;
(
    input  logic        clk,
    input  logic        i_rst_n,
    input  logic        i_lookup_valid,
    input  lookup_req_t i_lookup,
    input  vq_sel_t     i_hit_vec,
    input  line_t       i_entry_data [VQ_DEPTH],
    output lookup_rsp_t o_lookup
);

    offset_t offset;
    vq_idx_t hit_idx;
    line_t   hit_line;
    word_t   word;
    logic    hit;
    logic    hit_q;
    word_t   word_q;

    assign offset = i_lookup.addr[OFFSET_WIDTH-1:0];
    assign hit    = i_lookup_valid & (|i_hit_vec);

    // Lowest-indexed hit wins, scanning down so the last match sticks
    always_comb begin
        hit_idx = '0;
        for (int i = VQ_DEPTH - 1; i >= 0; i--) begin
            if (i_hit_vec[i]) begin
                hit_idx = vq_idx_t'(i);
            end
        end
    end

    assign hit_line = i_entry_data[hit_idx];

    // Bytes that would fall past the end of the line read as zero
    always_comb begin
        logic [OFFSET_WIDTH:0] byte_pos;
        offset_t               byte_idx;

        word = '0;
        for (int j = 0; j < DATA_SIZE; j++) begin
            byte_pos = {1'b0, offset} + (OFFSET_WIDTH+1)'(j);
            byte_idx = byte_pos[OFFSET_WIDTH-1:0];
            if (i_lookup.byte_sel[j] && (byte_pos < (OFFSET_WIDTH+1)'(LINE_SIZE))) begin
                word[j*8 +: 8] = hit_line[{byte_idx, 3'b000} +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            hit_q <= 1'b0;
        end else begin
            hit_q <= hit;
        end
    end

    always_ff @(posedge clk) begin
        word_q <= word;
    end

    assign o_lookup.hit  = hit_q;
    assign o_lookup.data = word_q;

endmodule

`default_nettype wire

/* logic/vq_writeback.sv */
// Victim queue writeback
// Sends the head entry to memory and pops it when memory reports done

`timescale 1ns/1ps
`default_nettype none

module vq_writeback
    import ccu_pkg::*;
(
    input  logic       clk,
    input  logic       i_rst_n,
    input  vq_idx_t    i_head,
    input  vq_sel_t    i_entry_valid,
    input  line_addr_t i_entry_addr [VQ_DEPTH],
    input  line_t      i_entry_data [VQ_DEPTH],
    input  logic       i_ccu_done,
    output logic       o_ccu_en,
    output ccu_req_t   o_ccu_req,
    output logic       o_pop
);

    wb_state_t state_q;
    wb_state_t state_d;
    ccu_req_t  req_q;
    logic      start;
    logic      done;

    assign start = (state_q == WB_IDLE) & i_entry_valid[i_head];
    // Memory done only counts while a request is outstanding
    assign done  = (state_q == WB_REQ) & i_ccu_done;

    always_comb begin
        state_d = state_q;
        case (state_q)
            WB_IDLE: begin
                if (start) begin
                    state_d = WB_REQ;
                end
            end
            WB_REQ: begin
                if (done) begin
                    state_d = WB_IDLE;
                end
            end
            default: state_d = WB_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state_q <= WB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Request is held stable until done
    always_ff @(posedge clk) begin
        if (start) begin
            req_q.addr <= i_entry_addr[i_head];
            req_q.data <= i_entry_data[i_head];
        end
    end

    assign o_ccu_en  = (state_q == WB_REQ);
    assign o_ccu_req = req_q;
    assign o_pop     = done;

endmodule

`default_nettype wire

/* logic/victim_queue.sv */
// Victim queue top level
// Buffers evicted data cache lines for loads until memory writeback

`timescale 1ns/1ps
`default_nettype none

module victim_queue
    import ccu_pkg::*;
(
    input  logic        clk,
    input  logic        i_rst_n,
    input  logic        i_victim_valid,
    input  victim_t     i_victim,
    output logic        o_full,
    input  logic        i_lookup_valid,
    input  lookup_req_t i_lookup,
    output lookup_rsp_t o_lookup,
    output logic        o_ccu_en,
    output ccu_req_t    o_ccu_req,
    input  logic        i_ccu_done
);

    vq_sel_t    alloc_sel;
    vq_sel_t    clear_sel;
    vq_idx_t    head;
    logic       pop;
    line_addr_t lookup_line_addr;
    vq_sel_t    entry_valid;
    vq_sel_t    hit_vec;
    line_addr_t entry_addr [VQ_DEPTH];
    line_t      entry_data [VQ_DEPTH];

    assign lookup_line_addr = i_lookup.addr[ADDR_WIDTH-1:OFFSET_WIDTH];

    vq_queue_ctrl u_queue_ctrl (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_victim_valid (i_victim_valid),
        .i_pop          (pop),
        .o_alloc_sel    (alloc_sel),
        .o_clear_sel    (clear_sel),
        .o_head         (head),
        .o_full         (o_full)
    );

    for (genvar i = 0; i < VQ_DEPTH; i++) begin : g_entry
        vq_entry u_entry (
            .clk           (clk),
            .i_rst_n       (i_rst_n),
            .i_alloc_en    (alloc_sel[i]),
            .i_alloc       (i_victim),
            .i_clear       (clear_sel[i]),
            .i_lookup_addr (lookup_line_addr),
            .o_valid       (entry_valid[i]),
            .o_line_addr   (entry_addr[i]),
            .o_data        (entry_data[i]),
            .o_hit         (hit_vec[i])
        );
    end

    vq_lookup u_lookup (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_lookup_valid (i_lookup_valid),
        .i_lookup       (i_lookup),
        .i_hit_vec      (hit_vec),
        .i_entry_data   (entry_data),
        .o_lookup       (o_lookup)
    );

    vq_writeback u_writeback (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_head        (head),
        .i_entry_valid (entry_valid),
        .i_entry_addr  (entry_addr),
        .i_entry_data  (entry_data),
        .i_ccu_done    (i_ccu_done),
        .o_ccu_en      (o_ccu_en),
        .o_ccu_req     (o_ccu_req),
        .o_pop         (pop)
    );

endmodule

`default_nettype wire

/* sim/tb_victim_queue.sv */
// Victim queue testbench
// Directed tests with a memory responder and an in-order scoreboard

`timescale 1ns/1ps
`default_nettype none

module tb_victim_queue
    import ccu_pkg::*;
;

    // Longest test drains four lines at up to ten cycles each, so this is generous
    localparam int TIMEOUT_CYCLES = 5000;
    localparam int CMP_WIDTH      = 288;

    typedef logic [CMP_WIDTH-1:0] cmp_t;

    logic        clk;
    logic        rst_n;
    logic        victim_valid;
    victim_t     victim;
    logic        full;
    logic        lookup_valid;
    lookup_req_t lookup;
    lookup_rsp_t lookup_rsp;
    logic        ccu_en;
    ccu_req_t    ccu_req;
    logic        ccu_done;

    int          seed = 82949;
    int          cycles;
    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    int          wb_count;
    logic        hold_done;
    string       cur_test;
    victim_t     sb [$];

    victim_queue dut0 (
        .clk            (clk),
        .i_rst_n        (rst_n),
        .i_victim_valid (victim_valid),
        .i_victim       (victim),
        .o_full         (full),
        .i_lookup_valid (lookup_valid),
        .i_lookup       (lookup),
        .o_lookup       (lookup_rsp),
        .o_ccu_en       (ccu_en),
        .o_ccu_req      (ccu_req),
        .i_ccu_done     (ccu_done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the tests did not finish", cycles);
        $display("Checks failed");
        $finish;
    end

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic victim_t random_victim(input line_addr_t addr);
        victim_t v;
        v.addr = addr;
        for (int i = 0; i < LINE_WIDTH / 32; i++) begin
            v.data[i*32 +: 32] = rand32();
        end
        return v;
    endfunction

    // Byte j is line byte offset plus j when selected and still inside the line
    function automatic word_t expected_word(input line_t line, input offset_t off,
                                            input byte_sel_t sel);
        word_t w;
        int    pos;
        w = '0;
        for (int j = 0; j < DATA_SIZE; j++) begin
            pos = int'(off) + j;
            if (sel[j] && pos < LINE_SIZE) begin
                w[j*8 +: 8] = line[pos*8 +: 8];
            end
        end
        return w;
    endfunction

    task automatic compare(input string what, input cmp_t exp, input cmp_t act);
        if (exp !== act) begin
            $display("error %s %s expected %0h actual %0h", cur_test, what, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("%s: %s", cur_test, msg);
        errors++;
        test_errors++;
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("%s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", cur_test, test_errors);
        end
    endtask

    task automatic enqueue(input victim_t v, output logic accepted);
        @(posedge clk);
        victim_valid <= 1'b1;
        victim       <= v;
        @(negedge clk);
        accepted = !full;
        if (accepted) begin
            sb.push_back(v);
        end
        @(posedge clk);
        victim_valid <= 1'b0;
    endtask

    // Answer arrives one cycle after the request cycle
    task automatic probe(input addr_t addr, input byte_sel_t sel, output lookup_rsp_t rsp);
        @(posedge clk);
        lookup_valid    <= 1'b1;
        lookup.addr     <= addr;
        lookup.byte_sel <= sel;
        @(posedge clk);
        lookup_valid <= 1'b0;
        @(negedge clk);
        rsp = lookup_rsp;
    endtask

    task automatic drain_queue();
        hold_done = 1'b0;
        while (sb.size() != 0 || ccu_en) begin
            @(negedge clk);
        end
        hold_done = 1'b1;
    endtask

    // Memory stand-in that checks each request against the oldest recorded victim
    initial begin : responder
        int       delay;
        victim_t  exp_v;
        ccu_req_t exp_req;
        ccu_done = 1'b0;
        forever begin
            @(negedge clk);
            if (ccu_en && !hold_done) begin
                delay = int'(rand32() % 8);
                repeat (delay) @(negedge clk);
                if (sb.size() == 0) begin
                    report_failure("writeback request with no victim pending");
                end else begin
                    exp_v        = sb.pop_front();
                    exp_req.addr = exp_v.addr;
                    exp_req.data = exp_v.data;
                    compare("writeback request", cmp_t'(exp_req), cmp_t'(ccu_req));
                end
                @(posedge clk);
                ccu_done <= 1'b1;
                @(posedge clk);
                ccu_done <= 1'b0;
                wb_count++;
            end
        end
    end

    task automatic test_reset_state();
        lookup_rsp_t rsp;
        start_test("reset_state");
        compare("o_full", cmp_t'(1'b0), cmp_t'(full));
        compare("o_ccu_en", cmp_t'(1'b0), cmp_t'(ccu_en));
        compare("lookup hit", cmp_t'(1'b0), cmp_t'(lookup_rsp.hit));
        probe(addr_t'(rand32()), 4'hf, rsp);
        compare("lookup hit", cmp_t'(1'b0), cmp_t'(rsp.hit));
        end_test();
    endtask

    task automatic test_hit_and_miss();
        victim_t     v;
        logic        acc;
        lookup_rsp_t rsp;
        lookup_rsp_t exp;
        offset_t     off;
        byte_sel_t   sel;
        start_test("lookup_hit_miss");
        hold_done = 1'b1;
        v = random_victim(line_addr_t'(rand32()));
        enqueue(v, acc);
        if (!acc) begin
            report_failure("victim was not accepted into an empty queue");
        end
        for (int k = 0; k < 8; k++) begin
            off = offset_t'(rand32() % 28);
            sel = byte_sel_t'(rand32());
            probe({v.addr, off}, sel, rsp);
            exp.hit  = 1'b1;
            exp.data = expected_word(v.data, off, sel);
            compare("lookup", cmp_t'(exp), cmp_t'(rsp));
        end
        // Matching address still on the bus but no request made
        @(negedge clk);
        compare("idle hit bit", cmp_t'(1'b0), cmp_t'(lookup_rsp.hit));
        probe({v.addr ^ line_addr_t'(1), 5'd0}, 4'hf, rsp);
        compare("miss hit bit", cmp_t'(1'b0), cmp_t'(rsp.hit));
        end_test();
    endtask

    task automatic test_end_of_line();
        victim_t     v;
        lookup_rsp_t rsp;
        lookup_rsp_t exp;
        offset_t     off;
        start_test("end_of_line");
        v = sb[0];
        for (int k = 29; k < 32; k++) begin
            off = offset_t'(k);
            probe({v.addr, off}, 4'hf, rsp);
            exp.hit  = 1'b1;
            exp.data = expected_word(v.data, off, 4'hf);
            compare("lookup", cmp_t'(exp), cmp_t'(rsp));
        end
        drain_queue();
        end_test();
    endtask

    task automatic test_fill_full();
        line_addr_t  base;
        victim_t     fifth;
        logic        acc;
        lookup_rsp_t rsp;
        start_test("fill_full");
        hold_done = 1'b1;
        base = line_addr_t'(rand32());
        for (int i = 0; i < VQ_DEPTH; i++) begin
            enqueue(random_victim(base + line_addr_t'(i)), acc);
            if (!acc) begin
                report_failure("victim was refused before the queue was full");
            end
        end
        @(negedge clk);
        compare("o_full", cmp_t'(1'b1), cmp_t'(full));
        fifth = random_victim(base + line_addr_t'(VQ_DEPTH));
        enqueue(fifth, acc);
        if (acc) begin
            report_failure("fifth victim was accepted while the queue was full");
        end
        probe({fifth.addr, 5'd0}, 4'hf, rsp);
        compare("fifth hit bit", cmp_t'(1'b0), cmp_t'(rsp.hit));
        end_test();
    endtask

    task automatic test_in_order_writeback();
        int   base;
        logic stray_en;
        start_test("in_order_writeback");
        base      = wb_count;
        stray_en  = 1'b0;
        hold_done = 1'b0;
        while (wb_count == base) begin
            @(negedge clk);
        end
        compare("o_full after first done", cmp_t'(1'b0), cmp_t'(full));
        while (sb.size() != 0 || ccu_en) begin
            @(negedge clk);
        end
        repeat (10) begin
            @(negedge clk);
            stray_en = stray_en | ccu_en;
        end
        if (stray_en) begin
            report_failure("o_ccu_en rose again after the last writeback");
        end
        hold_done = 1'b1;
        end_test();
    endtask

    task automatic test_hit_then_miss();
        victim_t     v;
        logic        acc;
        lookup_rsp_t rsp;
        lookup_rsp_t exp;
        start_test("hit_then_miss");
        hold_done = 1'b1;
        v = random_victim(line_addr_t'(rand32()));
        enqueue(v, acc);
        if (!acc) begin
            report_failure("victim was not accepted into an empty queue");
        end
        probe({v.addr, 5'd4}, 4'hf, rsp);
        exp.hit  = 1'b1;
        exp.data = expected_word(v.data, 5'd4, 4'hf);
        compare("pending lookup", cmp_t'(exp), cmp_t'(rsp));
        drain_queue();
        probe({v.addr, 5'd4}, 4'hf, rsp);
        compare("hit bit after writeback", cmp_t'(1'b0), cmp_t'(rsp.hit));
        end_test();
    endtask

    initial begin
        rst_n        = 1'b0;
        victim_valid = 1'b0;
        victim       = '0;
        lookup_valid = 1'b0;
        lookup       = '0;
        hold_done    = 1'b1;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        wb_count     = 0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        test_reset_state();
        test_hit_and_miss();
        test_end_of_line();
        test_fill_full();
        test_in_order_writeback();
        test_hit_then_miss();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
logic/ccu_pkg.sv
logic/vq_queue_ctrl.sv
logic/vq_entry.sv
logic/vq_lookup.sv
logic/vq_writeback.sv
logic/victim_queue.sv
sim/tb_victim_queue.sv

/* Makefile */
# Verilator build and run for the victim queue testbench

SOURCES := $(shell grep -v '^+' filelist.f)

obj_dir/Vtb_victim_queue: filelist.f $(SOURCES)
	verilator --binary --timing --top-module tb_victim_queue -f filelist.f

run: obj_dir/Vtb_victim_queue
	./obj_dir/Vtb_victim_queue > sim.log 2>&1 || true
	cat sim.log
	grep -q "^All checks passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
